//--- logic/mips_decode_params.svh
`ifndef MIPS_DECODE_PARAMS_SVH
`define MIPS_DECODE_PARAMS_SVH

// major opcodes
`define OP_RTYPE    6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_COP0     6'b010000
`define OP_SPECIAL2 6'b011100
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011
`define OP_CACHE    6'b101111
`define OP_PREF     6'b110011

// R-type functs
`define FN_SLL      6'b000000
`define FN_SRL      6'b000010
`define FN_SRA      6'b000011
`define FN_SLLV     6'b000100
`define FN_SRLV     6'b000110
`define FN_SRAV     6'b000111
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_SYSCALL  6'b001100
`define FN_BREAK    6'b001101
`define FN_SYNC     6'b001111
`define FN_MFHI     6'b010000
`define FN_MTHI     6'b010001
`define FN_MFLO     6'b010010
`define FN_MTLO     6'b010011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_XOR      6'b100110
`define FN_NOR      6'b100111
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011

// special2 functs
`define FN_MADD     6'b000000
`define FN_MADDU    6'b000001
`define FN_MUL      6'b000010
`define FN_MSUB     6'b000100
`define FN_MSUBU    6'b000101
`define FN_CLZ      6'b100000
`define FN_CLO      6'b100001

// COP0 functs outside the mfc0 and mtc0 rs codes
`define FN_TLBR     6'b000001
`define FN_TLBWI    6'b000010
`define FN_TLBWR    6'b000110
`define FN_TLBP     6'b001000
`define FN_ERET     6'b011000
`define FN_WAIT     6'b100000

`define RS_MFC0     5'b00000
`define RS_MTC0     5'b00100

// regimm rt codes
`define RT_BLTZ     5'b00000
`define RT_BGEZ     5'b00001
`define RT_BLTZAL   5'b10000
`define RT_BGEZAL   5'b10001

// destination select
`define REG_DST_RD  2'b00
`define REG_DST_RT  2'b01
`define REG_DST_R31 2'b10

`endif

//--- logic/mips_decode_pkg.sv
package mips_decode_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [1:0]  reg_dst_t;   // rd, rt or r31
	typedef logic [7:0]  ls_type_t;   // lw lh lhu lb lbu sw sh sb
	typedef logic [3:0]  tlb_type_t;  // tlbwr tlbwi tlbr tlbp

	// none sits at zero so a cleared word means no operation
	typedef enum logic [4:0] {
		alu_none = 5'd0,
		alu_add,
		alu_addu,
		alu_sub,
		alu_subu,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui,
		alu_clz,
		alu_clo
	} alu_op_e;

	typedef struct packed {
		logic      reg_write_en;
		reg_dst_t  reg_dst;
		logic      alu_imm_sel;  // srcb from immediate
		logic      sign_ext;
		logic      mem_read_en;
		logic      mem_write_en;
		logic      mem_to_reg;
		ls_type_t  ls_type;
		logic      hilo_wen;
		logic      hilo_to_reg;
		logic [1:0] mfhi_lo;     // {mfhi, mflo}
		logic      is_div;
		logic      is_mult;
		logic      cp0_wen;
		logic      cp0_to_reg;
		logic      brk;          // break
		logic      syscall;
		logic      eret;
		logic      ri;
		tlb_type_t tlb_type;
	} dec_ctrl_t;

	typedef struct packed {
		dec_ctrl_t ctrl;
		alu_op_e   alu_op;
		instr_t    instr;        // immediates are rebuilt downstream
	} ex_ctrl_t;

endpackage

//--- logic/main_decoder.sv
`timescale 1ns/10ps
`include "mips_decode_params.svh"

module main_decoder (
	input  mips_decode_pkg::instr_t    instr,
	output mips_decode_pkg::dec_ctrl_t ctrl
);
	import mips_decode_pkg::*;

	opcode_t  opcode;
	funct_t   funct;
	reg_idx_t rs;
	reg_idx_t rt;

	logic is_rtype, is_cop0, is_spec2;
	logic co_group;
	logic mul, madd, maddu, msub, msubu;
	logic mfhi, mflo;
	logic tlbwr, tlbwi, tlbr, tlbp;
	logic lw, lh, lhu, lb, lbu, sw, sh, sb;

	assign opcode = instr[31:26];
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign funct  = instr[5:0];

	assign is_rtype = (opcode == `OP_RTYPE);
	assign is_cop0  = (opcode == `OP_COP0);
	assign is_spec2 = (opcode == `OP_SPECIAL2);

	// eret, tlb and wait live outside the mfc0/mtc0 rs codes
	assign co_group = is_cop0 && (rs != `RS_MTC0) && (rs != `RS_MFC0);

	assign mul   = is_spec2 && (funct == `FN_MUL);
	assign madd  = is_spec2 && (funct == `FN_MADD);
	assign maddu = is_spec2 && (funct == `FN_MADDU);
	assign msub  = is_spec2 && (funct == `FN_MSUB);
	assign msubu = is_spec2 && (funct == `FN_MSUBU);

	assign mfhi = is_rtype && (funct == `FN_MFHI);
	assign mflo = is_rtype && (funct == `FN_MFLO);

	assign tlbwr = co_group && (funct == `FN_TLBWR);
	assign tlbwi = co_group && (funct == `FN_TLBWI);
	assign tlbr  = co_group && (funct == `FN_TLBR);
	assign tlbp  = co_group && (funct == `FN_TLBP);

	assign lw  = (opcode == `OP_LW);
	assign lh  = (opcode == `OP_LH);
	assign lhu = (opcode == `OP_LHU);
	assign lb  = (opcode == `OP_LB);
	assign lbu = (opcode == `OP_LBU);
	assign sw  = (opcode == `OP_SW);
	assign sh  = (opcode == `OP_SH);
	assign sb  = (opcode == `OP_SB);

	always_comb begin
		ctrl = '0;

		// zero extension only for the logic immediates and lui
		ctrl.sign_ext = !(opcode inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI});
		ctrl.ls_type  = {lw, lh, lhu, lb, lbu, sw, sh, sb};

		ctrl.hilo_wen = (is_rtype && (funct inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
			`FN_MTHI, `FN_MTLO})) || madd || maddu || msub || msubu;
		ctrl.hilo_to_reg = mfhi || mflo;
		ctrl.mfhi_lo     = {mfhi, mflo};
		ctrl.is_div  = is_rtype && (funct inside {`FN_DIV, `FN_DIVU});
		ctrl.is_mult = (is_rtype && (funct inside {`FN_MULT, `FN_MULTU}))
			|| mul || madd || maddu || msub || msubu;

		ctrl.cp0_wen    = is_cop0 && (rs == `RS_MTC0);
		ctrl.cp0_to_reg = is_cop0 && (rs == `RS_MFC0);
		ctrl.brk        = is_rtype && (funct == `FN_BREAK);
		ctrl.syscall    = is_rtype && (funct == `FN_SYSCALL);
		ctrl.eret       = co_group && (funct == `FN_ERET);
		ctrl.tlb_type   = {tlbwr, tlbwi, tlbr, tlbp};

		// register file and memory path per class
		case (opcode)
			`OP_RTYPE:
				case (funct)
					`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU,
					`FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
					`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
					`FN_MFHI, `FN_MFLO:
						{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_RD};
					`FN_JR, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_MTHI, `FN_MTLO,
					`FN_SYSCALL, `FN_BREAK, `FN_SYNC: ;  // no register write
					`FN_JALR:
						{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_R31}; // link to $ra
					default:
						ctrl.ri = 1'b1;
				endcase
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI:
				{ctrl.reg_write_en, ctrl.reg_dst, ctrl.alu_imm_sel} = {1'b1, `REG_DST_RT, 1'b1};
			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J: ;
			`OP_JAL:
				{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_R31};
			`OP_REGIMM:
				case (rt)
					`RT_BLTZ, `RT_BGEZ: ;
					`RT_BLTZAL, `RT_BGEZAL:
						{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_R31};
					default:
						ctrl.ri = 1'b1;
				endcase
			`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU: begin
				{ctrl.reg_write_en, ctrl.reg_dst, ctrl.alu_imm_sel} = {1'b1, `REG_DST_RT, 1'b1};
				ctrl.mem_read_en = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
			end
			`OP_SW, `OP_SH, `OP_SB: begin
				ctrl.alu_imm_sel  = 1'b1;  // address = rs + imm
				ctrl.mem_write_en = 1'b1;
			end
			`OP_COP0:
				case (rs)
					`RS_MTC0: ;
					`RS_MFC0:
						{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_RT};
					default:
						ctrl.ri = !(funct inside {`FN_ERET, `FN_TLBR, `FN_TLBP, `FN_TLBWI,
							`FN_TLBWR, `FN_WAIT});
				endcase
			`OP_SPECIAL2:
				case (funct)
					`FN_MUL, `FN_CLZ, `FN_CLO:
						{ctrl.reg_write_en, ctrl.reg_dst} = {1'b1, `REG_DST_RD};
					`FN_MADD, `FN_MADDU, `FN_MSUB, `FN_MSUBU: ;  // accumulate into hi/lo
					default:
						ctrl.ri = 1'b1;
				endcase
			`OP_CACHE, `OP_PREF: ;  // treated as nops
			default:
				ctrl.ri = 1'b1;
		endcase
	end

endmodule

//--- logic/alu_decoder.sv
`timescale 1ns/10ps
`include "mips_decode_params.svh"

module alu_decoder (
	input  mips_decode_pkg::instr_t  instr,
	output mips_decode_pkg::alu_op_e alu_op
);
	import mips_decode_pkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	always_comb begin
		alu_op = alu_none;
		case (opcode)
			`OP_RTYPE:
				case (funct)
					`FN_ADD:  alu_op = alu_add;
					`FN_ADDU: alu_op = alu_addu;
					`FN_SUB:  alu_op = alu_sub;
					`FN_SUBU: alu_op = alu_subu;
					`FN_AND:  alu_op = alu_and;
					`FN_OR:   alu_op = alu_or;
					`FN_XOR:  alu_op = alu_xor;
					`FN_NOR:  alu_op = alu_nor;
					`FN_SLT:  alu_op = alu_slt;
					`FN_SLTU: alu_op = alu_sltu;
					// variable shifts share the shifter ops
					`FN_SLL, `FN_SLLV: alu_op = alu_sll;
					`FN_SRL, `FN_SRLV: alu_op = alu_srl;
					`FN_SRA, `FN_SRAV: alu_op = alu_sra;
					default:  alu_op = alu_none;
				endcase
			`OP_ADDI:  alu_op = alu_add;   // traps on overflow
			`OP_ADDIU: alu_op = alu_addu;
			`OP_SLTI:  alu_op = alu_slt;
			`OP_SLTIU: alu_op = alu_sltu;
			`OP_ANDI:  alu_op = alu_and;
			`OP_ORI:   alu_op = alu_or;
			`OP_XORI:  alu_op = alu_xor;
			`OP_LUI:   alu_op = alu_lui;
			// address generation
			`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU,
			`OP_SW, `OP_SH, `OP_SB:
				alu_op = alu_addu;
			`OP_SPECIAL2:
				case (funct)
					`FN_CLZ: alu_op = alu_clz;
					`FN_CLO: alu_op = alu_clo;
					default: alu_op = alu_none;
				endcase
			default:
				alu_op = alu_none;
		endcase
	end

endmodule

//--- logic/id_ex_reg.sv
`timescale 1ns/10ps

module id_ex_reg (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      stall,
	input  logic                      flush,
	input  mips_decode_pkg::ex_ctrl_t d,
	input  logic                      d_valid,
	output mips_decode_pkg::ex_ctrl_t q,
	output logic                      q_valid
);

	// flush beats stall and leaves an all zero bubble
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			q       <= '0;
			q_valid <= 1'b0;
		end else if (flush) begin
			q       <= '0;
			q_valid <= 1'b0;
		end else if (!stall) begin
			q       <= d;
			q_valid <= d_valid;
		end
		// stall holds q
	end

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/10ps

module decode_unit (
	input  logic                      clk,
	input  logic                      rst_n,
	input  mips_decode_pkg::instr_t   instr,
	input  logic                      instr_valid,
	input  logic                      stall,
	input  logic                      flush,
	output mips_decode_pkg::ex_ctrl_t ex_ctrl,
	output logic                      ex_valid
);
	import mips_decode_pkg::*;

	dec_ctrl_t dec_ctrl;
	alu_op_e   alu_op;
	ex_ctrl_t  id_word;

	main_decoder u_main_dec (
		.instr (instr),
		.ctrl  (dec_ctrl)
	);

	alu_decoder u_alu_dec (
		.instr  (instr),
		.alu_op (alu_op)
	);

	// combined control word for EX
	assign id_word = '{ctrl: dec_ctrl, alu_op: alu_op, instr: instr};

	id_ex_reg u_id_ex (
		.clk     (clk),
		.rst_n   (rst_n),
		.stall   (stall),
		.flush   (flush),
		.d       (id_word),
		.d_valid (instr_valid),
		.q       (ex_ctrl),
		.q_valid (ex_valid)
	);

endmodule

//--- bench/decode_unit_checker.sv
`timescale 1ns/10ps
`include "mips_decode_params.svh"

module decode_unit_checker (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      stall,
	input logic                      flush,
	input mips_decode_pkg::ex_ctrl_t ex_ctrl,
	input logic                      ex_valid
);
	import mips_decode_pkg::*;

	dec_ctrl_t c;

	assign c = ex_ctrl.ctrl;

	// a load always writes rt from memory
	load_writes_rt: assert property (@(posedge clk) disable iff (!rst_n)
		c.mem_read_en |-> (c.reg_write_en && c.mem_to_reg && c.reg_dst == `REG_DST_RT))
		else $error("registered load without rt write back");

	store_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		c.mem_write_en |-> !c.reg_write_en)
		else $error("registered store writes the register file");

	ls_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(c.ls_type))
		else $error("ls_type has more than one bit set");

	tlb_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(c.tlb_type))
		else $error("tlb_type has more than one bit set");

	flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		flush |=> !ex_valid)
		else $error("ex_valid high after a flush");

	// flush wins, so only a plain stall holds
	stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && !flush) |=> ($stable(ex_ctrl) && $stable(ex_valid)))
		else $error("outputs moved during a stall");

	reset_clears: assert property (@(posedge clk)
		!rst_n |=> (!ex_valid && ex_ctrl == '0))
		else $error("outputs not cleared by reset");

endmodule

//--- bench/decode_unit_tb.sv
`timescale 1ns/10ps
`include "mips_decode_params.svh"

module decode_unit_tb;
	import mips_decode_pkg::*;

	localparam int n_random    = 300;
	localparam int test_cycles = 10 + 5 + 120 + n_random + 20;

	localparam funct_t rtype_fns [0:27] = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV,
		`FN_SRAV, `FN_JR, `FN_JALR, `FN_SYSCALL, `FN_BREAK, `FN_SYNC, `FN_MFHI, `FN_MTHI,
		`FN_MFLO, `FN_MTLO, `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_ADD, `FN_ADDU,
		`FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLT};
	localparam opcode_t itype_ops [0:16] = '{`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
		`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J,
		`OP_JAL, `OP_CACHE, `OP_PREF, 6'b111111};
	localparam opcode_t mem_ops [0:7] = '{`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU,
		`OP_SW, `OP_SH, `OP_SB};
	localparam funct_t spec2_fns [0:7] = '{`FN_MADD, `FN_MADDU, `FN_MUL, `FN_MSUB,
		`FN_MSUBU, `FN_CLZ, `FN_CLO, 6'b111000};
	localparam funct_t co_fns [0:6] = '{`FN_TLBR, `FN_TLBWI, `FN_TLBWR, `FN_TLBP,
		`FN_ERET, `FN_WAIT, 6'b111111};
	localparam reg_idx_t regimm_rts [0:4] = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL,
		5'b00010};

	logic     clk;
	logic     rst_n;
	instr_t   instr;
	logic     instr_valid;
	logic     stall;
	logic     flush;
	ex_ctrl_t ex_ctrl;
	logic     ex_valid;

	ex_ctrl_t    exp_word;
	logic        exp_valid;
	logic [31:0] rng_state;

	decode_unit UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.stall       (stall),
		.flush       (flush),
		.ex_ctrl     (ex_ctrl),
		.ex_valid    (ex_valid)
	);

	bind decode_unit decode_unit_checker u_chk (
		.clk      (clk),
		.rst_n    (rst_n),
		.stall    (stall),
		.flush    (flush),
		.ex_ctrl  (ex_ctrl),
		.ex_valid (ex_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// expected control word from the decode rules
	function automatic dec_ctrl_t model_ctrl(instr_t w);
		dec_ctrl_t c;
		opcode_t   op;
		funct_t    fn;
		reg_idx_t  rs;
		reg_idx_t  rt;
		op = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		fn = w[5:0];
		c = '0;
		c.sign_ext = !(op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI || op == `OP_LUI);
		case (op)
			`OP_RTYPE: case (fn)
				`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU, `FN_AND, `FN_OR,
				`FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
					c.reg_write_en = 1'b1;
					c.reg_dst = `REG_DST_RD;
				end
				`FN_MFHI, `FN_MFLO: begin
					c.reg_write_en = 1'b1;
					c.reg_dst = `REG_DST_RD;
					c.hilo_to_reg = 1'b1;
					c.mfhi_lo = (fn == `FN_MFHI) ? 2'b10 : 2'b01;
				end
				`FN_JALR: begin
					c.reg_write_en = 1'b1;
					c.reg_dst = `REG_DST_R31;
				end
				`FN_JR, `FN_SYNC: ;
				`FN_MULT, `FN_MULTU: {c.hilo_wen, c.is_mult} = 2'b11;
				`FN_DIV, `FN_DIVU:   {c.hilo_wen, c.is_div} = 2'b11;
				`FN_MTHI, `FN_MTLO:  c.hilo_wen = 1'b1;
				`FN_SYSCALL:         c.syscall = 1'b1;
				`FN_BREAK:           c.brk = 1'b1;
				default:             c.ri = 1'b1;
			endcase
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				c.reg_write_en = 1'b1;
				c.reg_dst = `REG_DST_RT;
				c.alu_imm_sel = 1'b1;
			end
			`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J, `OP_CACHE, `OP_PREF: ;
			`OP_JAL: {c.reg_write_en, c.reg_dst} = {1'b1, `REG_DST_R31};
			`OP_REGIMM: case (rt)
				`RT_BLTZ, `RT_BGEZ: ;
				`RT_BLTZAL, `RT_BGEZAL: {c.reg_write_en, c.reg_dst} = {1'b1, `REG_DST_R31};
				default: c.ri = 1'b1;
			endcase
			`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU: begin
				{c.reg_write_en, c.reg_dst, c.alu_imm_sel} = {1'b1, `REG_DST_RT, 1'b1};
				{c.mem_read_en, c.mem_to_reg} = 2'b11;
				c.ls_type = (op == `OP_LW) ? 8'h80 : (op == `OP_LH) ? 8'h40 :
					(op == `OP_LHU) ? 8'h20 : (op == `OP_LB) ? 8'h10 : 8'h08;
			end
			`OP_SW, `OP_SH, `OP_SB: begin
				{c.alu_imm_sel, c.mem_write_en} = 2'b11;
				c.ls_type = (op == `OP_SW) ? 8'h04 : (op == `OP_SH) ? 8'h02 : 8'h01;
			end
			`OP_COP0:
				if (rs == `RS_MTC0)
					c.cp0_wen = 1'b1;
				else if (rs == `RS_MFC0)
					{c.cp0_to_reg, c.reg_write_en, c.reg_dst} = {2'b11, `REG_DST_RT};
				else case (fn)
					`FN_ERET:  c.eret = 1'b1;
					`FN_TLBWR: c.tlb_type = 4'b1000;
					`FN_TLBWI: c.tlb_type = 4'b0100;
					`FN_TLBR:  c.tlb_type = 4'b0010;
					`FN_TLBP:  c.tlb_type = 4'b0001;
					`FN_WAIT:  ;
					default:   c.ri = 1'b1;
				endcase
			`OP_SPECIAL2: case (fn)
				`FN_MUL: {c.reg_write_en, c.reg_dst, c.is_mult} = {1'b1, `REG_DST_RD, 1'b1};
				`FN_CLZ, `FN_CLO: {c.reg_write_en, c.reg_dst} = {1'b1, `REG_DST_RD};
				`FN_MADD, `FN_MADDU, `FN_MSUB, `FN_MSUBU: {c.hilo_wen, c.is_mult} = 2'b11;
				default: c.ri = 1'b1;
			endcase
			default: c.ri = 1'b1;
		endcase
		return c;
	endfunction

	function automatic alu_op_e model_alu(instr_t w);
		opcode_t op;
		funct_t  fn;
		op = w[31:26];
		fn = w[5:0];
		case (op)
			`OP_RTYPE: case (fn)
				`FN_ADD:  return alu_add;
				`FN_ADDU: return alu_addu;
				`FN_SUB:  return alu_sub;
				`FN_SUBU: return alu_subu;
				`FN_AND:  return alu_and;
				`FN_OR:   return alu_or;
				`FN_XOR:  return alu_xor;
				`FN_NOR:  return alu_nor;
				`FN_SLT:  return alu_slt;
				`FN_SLTU: return alu_sltu;
				`FN_SLL, `FN_SLLV: return alu_sll;
				`FN_SRL, `FN_SRLV: return alu_srl;
				`FN_SRA, `FN_SRAV: return alu_sra;
				default:  return alu_none;
			endcase
			`OP_ADDI:  return alu_add;
			`OP_SLTI:  return alu_slt;
			`OP_SLTIU: return alu_sltu;
			`OP_ANDI:  return alu_and;
			`OP_ORI:   return alu_or;
			`OP_XORI:  return alu_xor;
			`OP_LUI:   return alu_lui;
			`OP_ADDIU, `OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU, `OP_SW, `OP_SH, `OP_SB:
				return alu_addu;
			`OP_SPECIAL2:
				return (fn == `FN_CLZ) ? alu_clz : (fn == `FN_CLO) ? alu_clo : alu_none;
			default:   return alu_none;
		endcase
	endfunction

	task automatic report_mismatch(input string field);
		$display("ERR %0d ns: %s differs from the model", $time, field);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic check_outputs();
		assert (ex_valid === exp_valid) else report_mismatch("ex_valid");
		assert (ex_ctrl.ctrl.reg_write_en === exp_word.ctrl.reg_write_en)
			else report_mismatch("reg_write_en");
		assert (ex_ctrl.ctrl.reg_dst === exp_word.ctrl.reg_dst) else report_mismatch("reg_dst");
		assert (ex_ctrl.ctrl.alu_imm_sel === exp_word.ctrl.alu_imm_sel)
			else report_mismatch("alu_imm_sel");
		assert (ex_ctrl.ctrl.sign_ext === exp_word.ctrl.sign_ext) else report_mismatch("sign_ext");
		assert (ex_ctrl.ctrl.mem_read_en === exp_word.ctrl.mem_read_en)
			else report_mismatch("mem_read_en");
		assert (ex_ctrl.ctrl.mem_write_en === exp_word.ctrl.mem_write_en)
			else report_mismatch("mem_write_en");
		assert (ex_ctrl.ctrl.mem_to_reg === exp_word.ctrl.mem_to_reg)
			else report_mismatch("mem_to_reg");
		assert (ex_ctrl.ctrl.ls_type === exp_word.ctrl.ls_type) else report_mismatch("ls_type");
		assert (ex_ctrl.ctrl.hilo_wen === exp_word.ctrl.hilo_wen) else report_mismatch("hilo_wen");
		assert (ex_ctrl.ctrl.hilo_to_reg === exp_word.ctrl.hilo_to_reg)
			else report_mismatch("hilo_to_reg");
		assert (ex_ctrl.ctrl.mfhi_lo === exp_word.ctrl.mfhi_lo) else report_mismatch("mfhi_lo");
		assert (ex_ctrl.ctrl.is_div === exp_word.ctrl.is_div) else report_mismatch("is_div");
		assert (ex_ctrl.ctrl.is_mult === exp_word.ctrl.is_mult) else report_mismatch("is_mult");
		assert (ex_ctrl.ctrl.cp0_wen === exp_word.ctrl.cp0_wen) else report_mismatch("cp0_wen");
		assert (ex_ctrl.ctrl.cp0_to_reg === exp_word.ctrl.cp0_to_reg)
			else report_mismatch("cp0_to_reg");
		assert (ex_ctrl.ctrl.brk === exp_word.ctrl.brk) else report_mismatch("break");
		assert (ex_ctrl.ctrl.syscall === exp_word.ctrl.syscall) else report_mismatch("syscall");
		assert (ex_ctrl.ctrl.eret === exp_word.ctrl.eret) else report_mismatch("eret");
		assert (ex_ctrl.ctrl.ri === exp_word.ctrl.ri) else report_mismatch("ri");
		assert (ex_ctrl.ctrl.tlb_type === exp_word.ctrl.tlb_type) else report_mismatch("tlb_type");
		assert (ex_ctrl.alu_op === exp_word.alu_op) else report_mismatch("alu_op");
		assert (ex_ctrl.instr === exp_word.instr) else report_mismatch("instr");
	endtask

	// drive at edge+1, then check one edge later
	task automatic step(input instr_t w, input logic v, input logic s, input logic f);
		instr       = w;
		instr_valid = v;
		stall       = s;
		flush       = f;
		@(posedge clk);
		if (!rst_n || f) begin
			exp_word  = '0;
			exp_valid = 1'b0;
		end else if (!s) begin
			exp_word  = '{ctrl: model_ctrl(w), alu_op: model_alu(w), instr: w};
			exp_valid = v;
		end
		#1;
		check_outputs();
	endtask

	function automatic instr_t with_random_fields(opcode_t op, funct_t fn);
		logic [31:0] r;
		r = next_rand();
		return {op, r[25:6], fn};
	endfunction

	initial begin
		logic [31:0] r;
		instr_t      held;
		rng_state = 32'd7897;
		exp_word  = '0;
		exp_valid = 1'b0;
		rst_n     = 1'b0;
		instr     = '0;
		instr_valid = 1'b0;
		stall     = 1'b0;
		flush     = 1'b0;

		repeat (10) step(next_rand(), 1'b1, 1'b0, 1'b0);
		rst_n = 1'b1;
		repeat (4) step(next_rand(), 1'b0, 1'b1, 1'b0);  // idle with the word still zero

		foreach (rtype_fns[i]) step(with_random_fields(`OP_RTYPE, rtype_fns[i]), 1'b1, 1'b0, 1'b0);
		step(with_random_fields(`OP_RTYPE, `FN_SLTU), 1'b1, 1'b0, 1'b0);
		step(with_random_fields(`OP_RTYPE, 6'b000001), 1'b1, 1'b0, 1'b0);
		step(with_random_fields(`OP_RTYPE, 6'b111111), 1'b1, 1'b0, 1'b0);
		foreach (itype_ops[i]) step(next_rand() & 32'h03ff_ffff | {itype_ops[i], 26'd0},
			1'b1, 1'b0, 1'b0);
		foreach (mem_ops[i]) step({mem_ops[i], 26'd0} | next_rand() & 32'h03ff_ffff,
			1'b1, 1'b0, 1'b0);
		foreach (regimm_rts[i]) begin
			r = next_rand();
			step({`OP_REGIMM, r[25:21], regimm_rts[i], r[15:0]}, 1'b1, 1'b0, 1'b0);
		end
		foreach (spec2_fns[i]) step(with_random_fields(`OP_SPECIAL2, spec2_fns[i]),
			1'b1, 1'b0, 1'b0);
		foreach (co_fns[i]) begin
			r = next_rand();
			step({`OP_COP0, 5'b10000, r[20:6], co_fns[i]}, 1'b1, 1'b0, 1'b0);
		end
		r = next_rand();
		step({`OP_COP0, `RS_MTC0, r[20:0]}, 1'b1, 1'b0, 1'b0);
		step({`OP_COP0, `RS_MFC0, r[20:0]}, 1'b1, 1'b0, 1'b0);

		// stall, flush, and both together
		held = with_random_fields(`OP_RTYPE, `FN_ADD);
		step(held, 1'b1, 1'b0, 1'b0);
		repeat (5) step(next_rand(), 1'b1, 1'b1, 1'b0);
		step(held, 1'b1, 1'b0, 1'b1);
		step(held, 1'b1, 1'b0, 1'b0);
		step(next_rand(), 1'b1, 1'b1, 1'b1);
		step({`OP_LW, 26'd0}, 1'b1, 1'b0, 1'b0);

		for (int i = 0; i < n_random; i++) begin
			r = next_rand();
			step(next_rand(), r[0], r[3:1] == 3'd0, r[7:4] == 4'd0);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		#(test_cycles * 8 + 100);
		$display("timeout: the run did not finish within %0d ns", test_cycles * 8 + 100);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- decode_unit.f
+incdir+logic
logic/mips_decode_pkg.sv
logic/main_decoder.sv
logic/alu_decoder.sv
logic/id_ex_reg.sv
logic/decode_unit.sv
bench/decode_unit_checker.sv
bench/decode_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --top-module decode_unit_tb \
	-f decode_unit.f -o decode_unit_sim > build.log 2>&1 &&
	./obj_dir/decode_unit_sim > sim.log 2>&1 ||
	echo "build or simulation ended with an error, see build.log and sim.log"
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
